// File: nmr_seq_top.f
+incdir+.
sram_pkg.sv
seq_cmd_pkg.sv
seg_fifo_if.sv
cmd_fetch.sv
seg_fifo.sv
pulse_player.sv
nmr_seq_top.sv
nmr_seq_checker.sv
tb_nmr_seq.sv

// File: Makefile
TOP := tb_nmr_seq

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f nmr_seq_top.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: tb_nmr_seq.sv
// nmr sequencer testbench
// builds random command programs, models the program ram and drives start
`include "nmr_seq_config.svh"

module tb_nmr_seq;
	timeunit 1ns;
	timeprecision 1ps;
	import sram_pkg::*;
	import seq_cmd_pkg::*;

	localparam int          NUM_PROGS    = 20;
	localparam int          RAM_WORDS    = 1 << `SRAM_ADDR_WIDTH;
	localparam int          DONE_TIMEOUT = 5000;   // clocks, longest run is near 1000
	localparam int          IDLE_TIMEOUT = 20;
	localparam logic [31:0] SEED         = 32'h96af_5c32;

	logic        clock_50;
	logic        rst;
	logic        start;
	sram_addr_t  sram_addr;
	logic        sram_cs;
	sram_word_t  sram_rd_dat;
	logic        pulse_out;
	logic        busy;
	logic        done;
	logic        underrun;

	sram_word_t  ram [RAM_WORDS];   // program memory
	logic        rd_pending;        // read issued in the last clock
	sram_addr_t  rd_addr;
	logic [31:0] rng;               // xorshift state
	int          check_errors;
	int          check_runs;
	int          tb_errors;
	int          started;           // programs launched
	logic        ok;

	nmr_seq_top uut (
		.clock_50    (clock_50),
		.rst         (rst),
		.start       (start),
		.sram_addr   (sram_addr),
		.sram_cs     (sram_cs),
		.sram_rd_dat (sram_rd_dat),
		.pulse_out   (pulse_out),
		.busy        (busy),
		.done        (done),
		.underrun    (underrun)
	);

	nmr_seq_checker u_check (
		.clk       (clock_50),
		.rst       (rst),
		.start     (start),
		.sram_cs   (sram_cs),
		.pulse_out (pulse_out),
		.busy      (busy),
		.done      (done),
		.underrun  (underrun),
		.prog      (ram),
		.errors    (check_errors),
		.runs      (check_runs)
	);

	initial begin
		clock_50 = 1'b0;
		forever #10 clock_50 = ~clock_50;   // 50 MHz
	end

	// ==============================
	// program ram model
	// ==============================
	always @(negedge clock_50) begin
		rd_pending = sram_cs;
		rd_addr    = sram_addr;
	end

	always @(posedge clock_50) begin
		#1;
		if (rd_pending)
			sram_rd_dat = ram[rd_addr];   // word for the data clock
	end

	// ==============================
	// random programs
	// ==============================
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return next_rand() % n;
	endfunction

	// unused words, pattern over the whole address
	function automatic sram_word_t fill_word(input sram_addr_t a);
		return {8{a, ~a}};
	endfunction

	function automatic sram_word_t cmd_word(input logic [7:0] op, input logic [63:0] low);
		sram_word_t w;
		w = '0;
		w[`SRAM_DAT_WIDTH-1 -: `CMD_WIDTH] = op;
		w[95:64] = next_rand();   // noise in unused bits
		w[63:0]  = low;
		return w;
	endfunction

	task automatic build_program();
		int unsigned n_play;
		int unsigned body_len;
		int unsigned pre_len;
		logic        use_loop;
		logic        in_body;
		logic        zero_used;
		seg_dur_t    dur;
		sram_addr_t  addr;
		for (int a = 0; a < RAM_WORDS; a++)
			ram[sram_addr_t'(a)] = fill_word(sram_addr_t'(a));
		n_play    = 1 + rand_below(6);
		use_loop  = rand_below(2) == 1;
		body_len  = use_loop ? 1 + rand_below(n_play) : 0;
		pre_len   = rand_below(n_play - body_len + 1);
		zero_used = 1'b0;
		addr      = '0;
		for (int unsigned i = 0; i < n_play; i++) begin
			in_body = use_loop && i >= pre_len && i < pre_len + body_len;
			if (use_loop && i == pre_len) begin
				ram[addr] = cmd_word(OP_LOOP, 64'(rand_below(5)));   // count 0..4
				addr      = addr + 1'b1;
			end
			dur = seg_dur_t'(8 + rand_below(33));
			// one zero duration at most, never first and never inside the loop
			if (i > 0 && !in_body && !zero_used && rand_below(4) == 0) begin
				dur       = '0;
				zero_used = 1'b1;
			end
			ram[addr] = cmd_word(OP_PLAY, {31'b0, rand_below(2) == 1, dur});
			addr      = addr + 1'b1;
			if (in_body && i == pre_len + body_len - 1) begin
				ram[addr] = cmd_word(OP_ENDLOOP, 64'(next_rand()));
				addr      = addr + 1'b1;
			end
		end
		if (rand_below(4) == 0)
			ram[addr] = cmd_word(8'(4 + rand_below(252)), 64'(next_rand()));   // unknown op
		else
			ram[addr] = cmd_word(OP_STOP, 64'(next_rand()));
	endtask

	// ==============================
	// stimulus
	// ==============================
	task automatic pulse_start();
		@(posedge clock_50);
		#1 start = 1'b1;
		@(posedge clock_50);
		#1 start = 1'b0;
	endtask

	task automatic wait_idle(output logic idle);
		idle = 1'b0;
		for (int n = 0; n < IDLE_TIMEOUT && !idle; n++) begin
			@(negedge clock_50);
			idle = !busy;
		end
	endtask

	task automatic wait_done(output logic seen);
		seen = 1'b0;
		for (int n = 0; n < DONE_TIMEOUT && !seen; n++) begin
			@(negedge clock_50);
			seen = done;
		end
	endtask

	initial begin
		rst         = 1'b1;
		start       = 1'b0;
		sram_rd_dat = '0;
		rd_pending  = 1'b0;
		rd_addr     = '0;
		rng         = SEED;
		tb_errors   = 0;
		started     = 0;
		ok          = 1'b1;
		repeat (3) @(posedge clock_50);
		#1 rst = 1'b0;
		repeat (6) @(posedge clock_50);   // quiet stretch after reset
		for (int p = 0; p < NUM_PROGS && ok; p++) begin
			build_program();
			wait_idle(ok);
			if (!ok) begin
				$display("busy did not drop before program %0d", p);
				tb_errors++;
			end else begin
				pulse_start();
				started++;
				if (rand_below(2) == 1) begin
					repeat (rand_below(4)) @(posedge clock_50);
					pulse_start();   // lands mid run
				end
				wait_done(ok);
				if (!ok) begin
					$display("timeout: no done pulse for program %0d within %0d clocks",
						p, DONE_TIMEOUT);
					tb_errors++;
				end
			end
		end
		repeat (4) @(posedge clock_50);
		if (ok && check_runs != started) begin
			$display("%0d done pulses seen for %0d started programs", check_runs, started);
			tb_errors++;
		end
		$display("summary: %0d programs, %0d check errors, %0d testbench errors",
			started, check_errors, tb_errors);
		if (check_errors == 0 && tb_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: nmr_seq_checker.sv
// sequencer checker
// rebuilds the expected pulse train of each run and compares it with the dut outputs
`include "nmr_seq_config.svh"

module nmr_seq_checker (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 sram_cs,
	input  logic                 pulse_out,
	input  logic                 busy,
	input  logic                 done,
	input  logic                 underrun,
	input  sram_pkg::sram_word_t prog [1 << `SRAM_ADDR_WIDTH],
	output int                   errors,
	output int                   runs
);
	timeunit 1ns;
	timeprecision 1ps;
	import sram_pkg::*;
	import seq_cmd_pkg::*;

	bit   exp_levels [$];       // expected pulse_out per clock
	bit   hist [$];             // pulse_out seen in the run
	int   exp_lead   = 0;       // idle clocks from start to the first segment
	logic in_run     = 1'b0;
	logic seen_start = 1'b0;
	int   err_cnt    = 0;
	int   run_cnt    = 0;

	assign errors = err_cnt;
	assign runs   = run_cnt;

	// ==============================
	// program expansion
	// ==============================
	task automatic expand_program();
		sram_addr_t pc;
		sram_addr_t body_start;
		int         passes;   // loop passes still owed
		int         len;
		int         steps;
		sram_word_t w;
		opcode_t    op;
		logic       stop;
		exp_levels.delete();
		exp_lead   = -1;
		pc         = '0;
		body_start = '0;
		passes     = 0;
		steps      = 0;
		stop       = 1'b0;
		while (!stop && steps < 4096) begin
			steps++;
			w  = prog[pc];
			op = opcode_t'(w[`SRAM_DAT_WIDTH-1 -: `CMD_WIDTH]);
			if (pc == {`SRAM_ADDR_WIDTH{1'b1}}) begin
				stop = 1'b1;   // top word always ends
			end else begin
				case (op)
					OP_PLAY: begin
						if (exp_lead < 0)
							exp_lead = 2 * steps + 1;   // two clocks per word, then fifo and player
						len = (w[`CNT_WIDTH-1:0] == '0) ? 1 : int'(w[`CNT_WIDTH-1:0]);
						repeat (len) exp_levels.push_back(w[`CNT_WIDTH]);
						pc = pc + 1'b1;
					end
					OP_LOOP: begin
						body_start = pc + 1'b1;
						passes     = (w[`LOOP_WIDTH-1:0] == '0) ? 1 : int'(w[`LOOP_WIDTH-1:0]);
						pc         = pc + 1'b1;
					end
					OP_ENDLOOP: begin
						passes--;
						pc = (passes > 0) ? body_start : pc + 1'b1;
					end
					default: stop = 1'b1;   // stop and unknown codes
				endcase
			end
		end
		if (exp_lead < 0)
			exp_lead = 2 * steps + 1;   // marker only
	endtask

	// tail must match after the idle lead-in of the fetch
	task automatic compare_run();
		int  offset;
		int  bad;
		bit  want;
		bad = 0;
		if (hist.size() < exp_levels.size()) begin
			$display("Fail %0t: run %0d lasted %0d clocks, expected at least %0d",
				$time, run_cnt, hist.size(), exp_levels.size());
			err_cnt++;
		end else begin
			offset = hist.size() - exp_levels.size();
			if (offset != exp_lead) begin
				$display("Fail %0t: run %0d first segment after %0d idle clocks, expected %0d",
					$time, run_cnt, offset, exp_lead);
				err_cnt++;
			end
			for (int i = 0; i < hist.size(); i++) begin
				if (i < offset)
					want = 1'b0;
				else
					want = exp_levels[i - offset];
				if (hist[i] != want) begin
					if (bad == 0)
						$display("Fail %0t: run %0d clock %0d pulse_out %0b, expected %0b",
							$time, run_cnt, i, hist[i], want);
					bad++;
				end
			end
			err_cnt += bad;
		end
	endtask

	// ==============================
	// per clock sampling
	// ==============================
	always @(negedge clk) begin
		if (rst) begin
			in_run = 1'b0;
			hist.delete();
		end else begin
			if (!seen_start && (sram_cs || busy || done || pulse_out || underrun)) begin
				$display("Fail %0t: outputs active before the first start", $time);
				err_cnt++;
			end
			if (underrun) begin
				$display("Fail %0t: underrun set", $time);
				err_cnt++;
			end
			if (busy != in_run) begin
				$display("Fail %0t: busy %0b, expected %0b", $time, busy, in_run);
				err_cnt++;
			end
			if (in_run && done) begin
				if (pulse_out) begin
					$display("Fail %0t: pulse_out high on the done clock", $time);
					err_cnt++;
				end
				compare_run();
				run_cnt++;
				in_run = 1'b0;
			end else if (in_run) begin
				hist.push_back(pulse_out);
			end else if (done) begin
				$display("Fail %0t: done outside a run", $time);
				err_cnt++;
			end else if (start) begin
				seen_start = 1'b1;   // taken on the coming edge
				in_run     = 1'b1;
				hist.delete();
				expand_program();
			end
		end
	end

endmodule

// File: nmr_seq_top.sv
// nmr pulse sequencer
// plays a command program from the external ram onto one gpio bit
module nmr_seq_top (
	input  logic                 clock_50,
	input  logic                 rst,
	input  logic                 start,        // run strobe
	output sram_pkg::sram_addr_t sram_addr,
	output logic                 sram_cs,
	input  sram_pkg::sram_word_t sram_rd_dat,
	output logic                 pulse_out,    // gpio bit
	output logic                 busy,
	output logic                 done,
	output logic                 underrun
);

	// ==============================
	// fetcher to player path
	// ==============================
	seg_fifo_if seg_if ();

	cmd_fetch u_fetch (
		.clk         (clock_50),
		.rst         (rst),
		.start       (start),
		.done        (done),          // releases busy
		.sram_addr   (sram_addr),
		.sram_cs     (sram_cs),
		.sram_rd_dat (sram_rd_dat),
		.busy        (busy),
		.fifo        (seg_if.producer)
	);

	seg_fifo u_fifo (
		.clk  (clock_50),
		.rst  (rst),
		.fifo (seg_if.buffer)
	);

	pulse_player u_player (
		.clk       (clock_50),
		.rst       (rst),
		.start     (start),
		.fifo      (seg_if.consumer),
		.pulse_out (pulse_out),
		.done      (done),
		.underrun  (underrun)
	);

endmodule

// File: pulse_player.sv
// pulse player
// times segments from the fifo onto the output bit, back to back,
// and flags the end of the program and any starved segment
module pulse_player (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,       // clears underrun when a run begins
	seg_fifo_if.consumer  fifo,
	output logic          pulse_out,
	output logic          done,        // one clock after the last segment
	output logic          underrun     // sticky until the next run
);
	import seq_cmd_pkg::*;

	logic     playing;   // segment on pulse_out
	logic     armed;     // inside a run from start to done
	seg_dur_t remain;    // clocks left including this one
	logic     seg_end;   // final clock of the segment

	assign seg_end = playing && (remain == seg_dur_t'(1));

	// pop on the final clock so the next segment abuts
	assign fifo.rd_en = !fifo.empty && (!playing || seg_end);

	always_ff @(posedge clk) begin
		if (rst) begin
			playing   <= 1'b0;
			armed     <= 1'b0;
			remain    <= '0;
			pulse_out <= 1'b0;
			done      <= 1'b0;
			underrun  <= 1'b0;
		end else begin
			done <= fifo.rd_en && fifo.rd_seg.last;   // marker reached
			if (start && !armed) begin
				armed    <= 1'b1;
				underrun <= 1'b0;
			end else if (done) begin
				armed <= 1'b0;
			end

			if (fifo.rd_en) begin
				if (fifo.rd_seg.last) begin
					playing   <= 1'b0;
					pulse_out <= 1'b0;   // low on the done clock
				end else begin
					playing   <= 1'b1;
					pulse_out <= fifo.rd_seg.level;
					remain    <= (fifo.rd_seg.dur == '0) ? seg_dur_t'(1) : fifo.rd_seg.dur;
				end
			end else if (seg_end) begin
				// segment over with nothing queued
				playing   <= 1'b0;
				pulse_out <= 1'b0;
				underrun  <= 1'b1;
			end else if (playing) begin
				remain <= remain - 1'b1;
			end
		end
	end

	// ==============================
	// checks
	// ==============================
	// output stays low between runs
	a_quiet_outside_run: assert property (@(posedge clk) disable iff (rst)
		!armed |-> !pulse_out);

	// segments only leave the fifo during an accepted run
	a_pop_in_run: assert property (@(posedge clk) disable iff (rst)
		fifo.rd_en |-> armed);

endmodule

// File: seg_fifo.sv
// segment fifo
// circular buffer of timed segments between fetcher and player
`include "nmr_seq_config.svh"

module seg_fifo (
	input  logic       clk,
	input  logic       rst,
	seg_fifo_if.buffer fifo
);
	import seq_cmd_pkg::*;

	localparam int DEPTH = `SEG_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	seg_t             mem [DEPTH];   // segment store
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;         // entries held

	assign fifo.rd_seg = mem[rd_ptr];              // head shown before pop
	assign fifo.empty  = (count == '0);
	assign fifo.full   = (count == CNT_W'(DEPTH));

	always_ff @(posedge clk) begin
		if (fifo.wr_en)
			mem[wr_ptr] <= fifo.wr_seg;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (fifo.wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
			if (fifo.rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({fifo.wr_en, fifo.rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;       // idle or push with pop
			endcase
		end
	end

	// ==============================
	// strobe rules
	// ==============================
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		fifo.rd_en |-> !fifo.empty);

	a_no_push_full: assert property (@(posedge clk) disable iff (rst)
		fifo.wr_en |-> !fifo.full);

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(DEPTH));

endmodule

// File: cmd_fetch.sv
// command fetcher
// walks the program ram from address 0, resolves one loop level
// and pushes play segments and the end marker into the segment fifo
`include "nmr_seq_config.svh"

module cmd_fetch (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,        // one-clock run request
	input  logic                 done,         // player finished the run
	output sram_pkg::sram_addr_t sram_addr,
	output logic                 sram_cs,
	input  sram_pkg::sram_word_t sram_rd_dat,  // valid one clock after sram_cs
	output logic                 busy,
	seg_fifo_if.producer         fifo
);
	import sram_pkg::*;
	import seq_cmd_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,   // waiting for start
		ST_ADDR,   // address on the ram
		ST_DATA,   // word on sram_rd_dat
		ST_PUSH    // segment held while the fifo is full
	} fetch_state_t;

	// ==============================
	// registers
	// ==============================
	fetch_state_t state;
	sram_addr_t   pc;          // word being fetched
	sram_addr_t   loop_addr;   // first word of the loop body
	loop_cnt_t    loop_cnt;    // passes still to run
	seg_t         seg_hold;    // segment parked while full

	// ==============================
	// word decode
	// ==============================
	opcode_t op;
	logic    at_end;      // word closes the program
	logic    push_word;   // word yields a segment
	seg_t    word_seg;

	always_comb begin
		op        = opcode_t'(sram_rd_dat[`SRAM_DAT_WIDTH-1 -: `CMD_WIDTH]);
		// unknown opcodes and the top address both stop the run
		at_end    = (pc == {`SRAM_ADDR_WIDTH{1'b1}}) ||
		            !(op inside {OP_PLAY, OP_LOOP, OP_ENDLOOP});
		push_word = at_end || (op == OP_PLAY);

		word_seg.last  = at_end;
		word_seg.level = at_end ? 1'b0 : sram_rd_dat[`CNT_WIDTH];      // bit 32
		word_seg.dur   = at_end ? '0 : sram_rd_dat[`CNT_WIDTH-1:0];
	end

	// ==============================
	// ram and fifo side
	// ==============================
	assign sram_cs     = (state == ST_ADDR);   // one read per word
	assign sram_addr   = pc;
	assign fifo.wr_seg = (state == ST_PUSH) ? seg_hold : word_seg;
	assign fifo.wr_en  = !fifo.full &&
	                     ((state == ST_DATA && push_word) || state == ST_PUSH);

	// ==============================
	// sequencing
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			pc        <= '0;
			loop_addr <= '0;
			loop_cnt  <= '0;
			busy      <= 1'b0;
		end else begin
			if (done)
				busy <= 1'b0;   // run ends with the player
			case (state)
				ST_IDLE: begin
					if (start && !busy) begin   // starts during a run are dropped
						state    <= ST_ADDR;
						pc       <= '0;
						loop_cnt <= '0;
						busy     <= 1'b1;
					end
				end
				ST_ADDR: state <= ST_DATA;
				ST_DATA: begin
					if (push_word) begin
						if (fifo.full)
							state <= ST_PUSH;       // retry from seg_hold
						else if (at_end)
							state <= ST_IDLE;       // marker pushed
						else begin
							pc    <= pc + 1'b1;
							state <= ST_ADDR;
						end
					end else if (op == OP_LOOP) begin
						loop_addr <= pc + 1'b1;    // body starts after the loop word
						loop_cnt  <= sram_rd_dat[`LOOP_WIDTH-1:0];
						pc        <= pc + 1'b1;
						state     <= ST_ADDR;
					end else begin
						// endloop falls through on a count of 0 or 1
						if (loop_cnt > loop_cnt_t'(1)) begin
							loop_cnt <= loop_cnt - 1'b1;
							pc       <= loop_addr;
						end else begin
							pc <= pc + 1'b1;
						end
						state <= ST_ADDR;
					end
				end
				ST_PUSH: begin
					if (!fifo.full) begin
						if (seg_hold.last)
							state <= ST_IDLE;
						else begin
							pc    <= pc + 1'b1;
							state <= ST_ADDR;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// parked copy of the decoded word
	always_ff @(posedge clk) begin
		if (state == ST_DATA)
			seg_hold <= word_seg;
	end

	// ==============================
	// checks
	// ==============================
	// the program ram is read only inside a run
	a_read_in_run: assert property (@(posedge clk) disable iff (rst)
		sram_cs |-> busy);

	// segments are pushed only inside a run
	a_push_in_run: assert property (@(posedge clk) disable iff (rst)
		fifo.wr_en |-> busy);

endmodule

// File: seg_fifo_if.sv
// segment fifo link
// joins the command fetcher, the segment fifo and the pulse player
interface seg_fifo_if;
	import seq_cmd_pkg::*;

	logic wr_en;    // push strobe, only while full is low
	seg_t wr_seg;   // segment to push
	logic full;     // no room for a push
	logic rd_en;    // pop strobe, only while empty is low
	seg_t rd_seg;   // head entry, valid before the pop
	logic empty;    // nothing to pop

	// fetcher side
	modport producer (output wr_en, output wr_seg, input full);

	// fifo storage
	modport buffer (
		input  wr_en, wr_seg, rd_en,
		output full, rd_seg, empty
	);

	// player side
	modport consumer (output rd_en, input rd_seg, empty);

endinterface

// File: seq_cmd_pkg.sv
// sequencer command types
// opcodes, word fields and the buffered segment format
`include "nmr_seq_config.svh"

package seq_cmd_pkg;

	// ==============================
	// opcode field, word bits 127..120
	// ==============================
	typedef enum logic [`CMD_WIDTH-1:0] {
		OP_STOP    = 8'd0,   // end of program
		OP_PLAY    = 8'd1,   // one timed segment
		OP_LOOP    = 8'd2,   // open loop, count in bits 15..0
		OP_ENDLOOP = 8'd3    // close loop, jump back while passes left
	} opcode_t;              // other values end the program too

	// ==============================
	// word fields
	// ==============================
	typedef logic [`CNT_WIDTH-1:0]  seg_dur_t;   // bits 31..0, zero plays one clock
	typedef logic [`LOOP_WIDTH-1:0] loop_cnt_t;  // bits 15..0, zero runs body once

	// ==============================
	// segment as held in the fifo
	// ==============================
	typedef struct packed {
		logic     last;    // end marker, never played
		logic     level;   // output level, word bit 32
		seg_dur_t dur;     // clocks at that level
	} seg_t;

endpackage

// File: sram_pkg.sv
// program ram types
// address and data word of the on-chip command memory
`include "nmr_seq_config.svh"

package sram_pkg;

	// word address into the program
	typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;

	// one full command word as read from the ram
	typedef logic [`SRAM_DAT_WIDTH-1:0] sram_word_t;

endpackage

// File: nmr_seq_config.svh
// nmr sequencer configuration
// bus widths and buffer depth shared by rtl and testbench
`ifndef NMR_SEQ_CONFIG_SVH
`define NMR_SEQ_CONFIG_SVH

// ==============================
// program ram
// ==============================
`define SRAM_ADDR_WIDTH 8     // 256 words of program
`define SRAM_DAT_WIDTH  128   // one command per word

// ==============================
// command word fields
// ==============================
`define CMD_WIDTH       8     // opcode, top bits of the word
`define CNT_WIDTH       32    // segment duration in clocks
`define LOOP_WIDTH      16    // loop repeat count

// ==============================
// segment buffer
// ==============================
`define SEG_FIFO_DEPTH  4     // entries between fetcher and player

`endif
